// ==== core_pkg.sv ====
package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN          = 32;
    localparam int REG_ADDR_W    = 5;
    localparam int SHAMT_W       = $clog2(XLEN);

    // Multiplier consumes one digit of the second operand per cycle
    localparam int MUL_STEP_BITS = 4;
    localparam int MUL_STEPS     = XLEN / MUL_STEP_BITS;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Operations and units
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SLT,
        OP_MUL
    } op_e;

    typedef enum logic {
        FU_ALU,
        FU_MUL
    } fu_e;

    //////////////////////////////////////////////////////////////////////
    // Grouped signals
    //////////////////////////////////////////////////////////////////////

    // Decoded instruction, imm replaces rs2 when use_imm is set
    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        word_t     imm;
    } instr_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
    } commit_t;

    // Bypass view of one execute stage
    typedef struct packed {
        logic      pending;
        reg_addr_t rd;
        logic      data_valid;
        word_t     data;
    } fwd_t;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/10ps

module reg_file import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  reg_addr_t ra_addr_i,
    output word_t     ra_data_o,
    input  reg_addr_t rb_addr_i,
    output word_t     rb_data_o,
    input  logic      we_i,
    input  reg_addr_t w_addr_i,
    input  word_t     w_data_i
);

    // Register 0 has no storage
    word_t regs_q [1:(1 << REG_ADDR_W) - 1];

    assign ra_data_o = (ra_addr_i == '0) ? '0 : regs_q[ra_addr_i];
    assign rb_data_o = (rb_addr_i == '0) ? '0 : regs_q[rb_addr_i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < (1 << REG_ADDR_W); i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && w_addr_i != '0) begin
            regs_q[w_addr_i] <= w_data_i;
        end
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps

module alu import core_pkg::*; (
    input  op_e   op_i,
    input  word_t a_i,
    input  word_t b_i,
    output word_t result_o
);

    logic [SHAMT_W-1:0] shamt;
    logic               less;

    assign shamt = b_i[SHAMT_W-1:0];
    assign less  = $signed(a_i) < $signed(b_i);

    always_comb begin
        unique case (op_i)
            OP_ADD: result_o = a_i + b_i;
            OP_SUB: result_o = a_i - b_i;
            OP_AND: result_o = a_i & b_i;
            OP_OR:  result_o = a_i | b_i;
            OP_XOR: result_o = a_i ^ b_i;
            OP_SLL: result_o = a_i << shamt;
            OP_SRL: result_o = a_i >> shamt;
            OP_SLT: result_o = {{(XLEN-1){1'b0}}, less};
            // Multiply result comes from the multiplier
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/10ps

module mul_unit import core_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  start_i,
    input  word_t a_i,
    input  word_t b_i,
    output logic  busy_o,
    output logic  done_o,
    output word_t product_o
);

    localparam int STEP_W = $clog2(MUL_STEPS);

    logic              busy_q;
    logic              done_q;
    logic [STEP_W-1:0] step_q;
    logic              last_step;

    word_t a_q;
    word_t b_q;
    word_t acc_q;
    word_t partial;

    // Multiplicand times the lowest remaining digit
    assign partial   = word_t'(a_q * b_q[MUL_STEP_BITS-1:0]);
    assign last_step = step_q == STEP_W'(MUL_STEPS - 1);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            step_q <= '0;
        end else begin
            done_q <= busy_q && last_step;
            if (start_i) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (last_step) busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            a_q   <= a_i;
            b_q   <= b_i;
            acc_q <= '0;
        end else if (busy_q) begin
            acc_q <= acc_q + partial;
            a_q   <= a_q << MUL_STEP_BITS;
            b_q   <= b_q >> MUL_STEP_BITS;
        end
    end

    assign busy_o    = busy_q;
    assign done_o    = done_q;
    assign product_o = acc_q;

endmodule

// ==== issue_stage.sv ====
`timescale 1ns/10ps

module issue_stage import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,

    input  logic      instr_valid_i,
    input  instr_t    instr_i,
    output logic      instr_ready_o,

    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,

    input  fwd_t      ex1_fwd_i,
    input  fwd_t      ex2_fwd_i,
    input  logic      ex1_ready_i,
    input  logic      mul_busy_i,

    output logic      issue_o,
    output fu_e       issue_fu_o,
    output reg_addr_t issue_rd_o,
    output word_t     op_a_o,
    output word_t     op_b_o,
    output op_e       instr_op_o
);

    logic   valid_q;
    instr_t instr_q;

    //////////////////////////////////////////////////////////////////////
    // Operand bypass
    //////////////////////////////////////////////////////////////////////

    // Returns {hazard, operand}, EX1 is younger so it takes priority
    function automatic logic [XLEN:0] bypass(reg_addr_t addr, word_t rf_data,
                                             fwd_t ex1, fwd_t ex2);
        logic [XLEN:0] res;
        res = {1'b0, rf_data};
        if (addr != '0) begin
            if (ex1.pending && ex1.rd == addr) begin
                res = {!ex1.data_valid, ex1.data};
            end else if (ex2.pending && ex2.rd == addr) begin
                res = {!ex2.data_valid, ex2.data};
            end
        end
        return res;
    endfunction

    logic [XLEN:0] rs1_sel;
    logic [XLEN:0] rs2_sel;
    logic          data_hazard;
    logic          struct_hazard;

    assign rs1_addr_o = instr_q.rs1;
    assign rs2_addr_o = instr_q.rs2;

    assign rs1_sel = bypass(instr_q.rs1, rs1_data_i, ex1_fwd_i, ex2_fwd_i);
    assign rs2_sel = bypass(instr_q.rs2, rs2_data_i, ex1_fwd_i, ex2_fwd_i);

    assign op_a_o = rs1_sel[XLEN-1:0];
    assign op_b_o = instr_q.use_imm ? instr_q.imm : rs2_sel[XLEN-1:0];

    //////////////////////////////////////////////////////////////////////
    // Hazards and issue
    //////////////////////////////////////////////////////////////////////

    // rs2 is not needed with an immediate
    assign data_hazard   = rs1_sel[XLEN] || (!instr_q.use_imm && rs2_sel[XLEN]);
    assign struct_hazard = !ex1_ready_i || (instr_q.op == OP_MUL && mul_busy_i);

    assign issue_o       = valid_q && !data_hazard && !struct_hazard;
    assign issue_fu_o    = (instr_q.op == OP_MUL) ? FU_MUL : FU_ALU;
    assign issue_rd_o    = instr_q.rd;
    assign instr_op_o    = instr_q.op;
    assign instr_ready_o = !valid_q || issue_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (instr_valid_i && instr_ready_o) begin
            valid_q <= 1'b1;
        end else if (issue_o) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i && instr_ready_o) instr_q <= instr_i;
    end

endmodule

// ==== exec_pipe.sv ====
`timescale 1ns/10ps

module exec_pipe import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      issue_i,
    input  fu_e       issue_fu_i,
    input  reg_addr_t issue_rd_i,
    input  word_t     alu_result_i,
    input  logic      mul_done_i,
    input  word_t     mul_product_i,
    output logic      ex1_ready_o,
    output fwd_t      ex1_fwd_o,
    output fwd_t      ex2_fwd_o,
    output logic      commit_valid_o,
    output commit_t   commit_o
);

    logic      ex1_pending_q, ex1_pending_d;
    reg_addr_t ex1_rd_q, ex1_rd_d;
    fu_e       ex1_sel_q, ex1_sel_d;
    word_t     ex1_data_q, ex1_data_d;
    logic      ex1_data_valid;
    word_t     ex1_data;

    logic      ex2_pending_q, ex2_pending_d;
    reg_addr_t ex2_rd_q, ex2_rd_d;
    fu_e       ex2_sel_q, ex2_sel_d;
    word_t     ex2_data_q, ex2_data_d;
    logic      ex2_data_valid;
    word_t     ex2_data;
    logic      ex2_ready;

    //////////////////////////////////////////////////////////////////////
    // Stage results
    //////////////////////////////////////////////////////////////////////

    // A done strobe goes to EX2 when EX2 is still waiting on the multiplier
    assign ex1_data_valid = (ex1_sel_q == FU_ALU) ||
                            (mul_done_i && !(ex2_pending_q && ex2_sel_q == FU_MUL));
    assign ex1_data       = (ex1_sel_q == FU_ALU) ? ex1_data_q : mul_product_i;
    assign ex2_data_valid = (ex2_sel_q == FU_ALU) || mul_done_i;
    assign ex2_data       = (ex2_sel_q == FU_ALU) ? ex2_data_q : mul_product_i;

    assign commit_valid_o = ex2_pending_q && ex2_data_valid;
    assign ex2_ready      = !ex2_pending_q || ex2_data_valid;
    assign ex1_ready_o    = !ex1_pending_q || ex2_ready;

    assign ex1_fwd_o = '{pending: ex1_pending_q, rd: ex1_rd_q,
                         data_valid: ex1_data_valid, data: ex1_data};
    assign ex2_fwd_o = '{pending: ex2_pending_q, rd: ex2_rd_q,
                         data_valid: ex2_data_valid, data: ex2_data};
    assign commit_o  = '{rd: ex2_rd_q, value: ex2_data};

    //////////////////////////////////////////////////////////////////////
    // Stage advance
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ex1_pending_d = ex1_pending_q;
        ex1_rd_d      = ex1_rd_q;
        ex1_sel_d     = ex1_sel_q;
        ex1_data_d    = ex1_data_q;
        ex2_pending_d = ex2_pending_q;
        ex2_rd_d      = ex2_rd_q;
        ex2_sel_d     = ex2_sel_q;
        ex2_data_d    = ex2_data_q;

        // Keep a product that arrived while EX1 is stalled
        if (ex1_data_valid) begin
            ex1_sel_d  = FU_ALU;
            ex1_data_d = ex1_data;
        end
        if (ex2_ready) begin
            ex1_pending_d = 1'b0;
            ex1_sel_d     = FU_ALU;
        end
        if (issue_i) begin
            ex1_pending_d = 1'b1;
            ex1_rd_d      = issue_rd_i;
            ex1_sel_d     = issue_fu_i;
            ex1_data_d    = alu_result_i;
        end

        if (commit_valid_o) begin
            ex2_pending_d = 1'b0;
            ex2_sel_d     = FU_ALU;
        end
        if (ex1_pending_q && ex2_ready) begin
            ex2_pending_d = 1'b1;
            ex2_rd_d      = ex1_rd_q;
            ex2_sel_d     = ex1_data_valid ? FU_ALU : ex1_sel_q;
            ex2_data_d    = ex1_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex1_pending_q <= 1'b0;
            ex1_rd_q      <= '0;
            ex1_sel_q     <= FU_ALU;
            ex2_pending_q <= 1'b0;
            ex2_rd_q      <= '0;
            ex2_sel_q     <= FU_ALU;
        end else begin
            ex1_pending_q <= ex1_pending_d;
            ex1_rd_q      <= ex1_rd_d;
            ex1_sel_q     <= ex1_sel_d;
            ex2_pending_q <= ex2_pending_d;
            ex2_rd_q      <= ex2_rd_d;
            ex2_sel_q     <= ex2_sel_d;
        end
    end

    always_ff @(posedge clk_i) begin
        ex1_data_q <= ex1_data_d;
        ex2_data_q <= ex2_data_d;
    end

endmodule

// ==== exec_core.sv ====
`timescale 1ns/10ps

module exec_core import core_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    instr_valid_i,
    input  instr_t  instr_i,
    output logic    instr_ready_o,
    output logic    commit_valid_o,
    output commit_t commit_o
);

    reg_addr_t rs1_addr, rs2_addr;
    word_t     rs1_data, rs2_data;
    fwd_t      ex1_fwd, ex2_fwd;
    logic      ex1_ready;
    logic      issue;
    fu_e       issue_fu;
    reg_addr_t issue_rd;
    word_t     op_a, op_b;
    op_e       instr_op;
    word_t     alu_result;
    logic      mul_busy, mul_done;
    word_t     mul_product;

    // Only multiply issues start the multiplier
    wire mul_start = issue && (issue_fu == FU_MUL);

    issue_stage u_issue (
        .clk_i, .rst_ni, .instr_valid_i, .instr_i, .instr_ready_o,
        .rs1_addr_o (rs1_addr),  .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),  .rs2_data_i (rs2_data),
        .ex1_fwd_i  (ex1_fwd),   .ex2_fwd_i  (ex2_fwd),
        .ex1_ready_i(ex1_ready), .mul_busy_i (mul_busy),
        .issue_o    (issue),     .issue_fu_o (issue_fu),
        .issue_rd_o (issue_rd),  .op_a_o     (op_a),
        .op_b_o     (op_b),      .instr_op_o (instr_op)
    );

    reg_file u_reg_file (
        .clk_i, .rst_ni,
        .ra_addr_i (rs1_addr), .ra_data_o (rs1_data),
        .rb_addr_i (rs2_addr), .rb_data_o (rs2_data),
        .we_i (commit_valid_o), .w_addr_i (commit_o.rd), .w_data_i (commit_o.value)
    );

    alu u_alu (.op_i (instr_op), .a_i (op_a), .b_i (op_b), .result_o (alu_result));

    mul_unit u_mul (
        .clk_i, .rst_ni, .start_i (mul_start), .a_i (op_a), .b_i (op_b),
        .busy_o (mul_busy), .done_o (mul_done), .product_o (mul_product)
    );

    exec_pipe u_pipe (
        .clk_i, .rst_ni,
        .issue_i (issue), .issue_fu_i (issue_fu), .issue_rd_i (issue_rd),
        .alu_result_i (alu_result), .mul_done_i (mul_done), .mul_product_i (mul_product),
        .ex1_ready_o (ex1_ready), .ex1_fwd_o (ex1_fwd), .ex2_fwd_o (ex2_fwd),
        .commit_valid_o, .commit_o
    );

endmodule

// ==== exec_core_properties.sv ====
`timescale 1ns/10ps

module exec_core_properties import core_pkg::*; (
    input logic clk_i,
    input logic rst_ni,
    input logic issue_i,
    input fu_e  issue_fu_i,
    input logic mul_done_i,
    input logic ex1_pending_q,
    input fu_e  ex1_sel_q,
    input logic ex2_pending_q,
    input fu_e  ex2_sel_q,
    input logic commit_valid_o
);

    // A stage still waiting for a product means the multiplier is occupied
    logic mul_waiting;

    // Instructions issued into EX1 and not yet committed
    logic [1:0] in_pipe_q;
    logic       issue_last_q;

    assign mul_waiting = (ex1_pending_q && ex1_sel_q == FU_MUL) ||
                         (ex2_pending_q && ex2_sel_q == FU_MUL);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            in_pipe_q    <= '0;
            issue_last_q <= 1'b0;
        end else begin
            in_pipe_q    <= in_pipe_q + 2'(issue_i) - 2'(commit_valid_o);
            issue_last_q <= issue_i;
        end
    end

    // Entries older than the last issue edge have reached EX2
    commit_needs_ex2: assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_valid_o |-> (in_pipe_q > {1'b0, issue_last_q}))
        else $error("commit fired with EX2 empty");

    mul_start_when_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (issue_i && issue_fu_i == FU_MUL) |-> (!mul_waiting || mul_done_i))
        else $error("multiply started while the multiplier was busy");

    no_commit_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !commit_valid_o)
        else $error("commit high during reset");

endmodule

bind exec_pipe exec_core_properties u_props (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_i        (issue_i),
    .issue_fu_i     (issue_fu_i),
    .mul_done_i     (mul_done_i),
    .ex1_pending_q  (ex1_pending_q),
    .ex1_sel_q      (ex1_sel_q),
    .ex2_pending_q  (ex2_pending_q),
    .ex2_sel_q      (ex2_sel_q),
    .commit_valid_o (commit_valid_o)
);

// ==== tb_exec_core.sv ====
`timescale 1ns/10ps

module tb_exec_core import core_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;

    logic    clk_i;
    logic    rst_ni;
    logic    instr_valid_i;
    instr_t  instr_i;
    logic    instr_ready_o;
    logic    commit_valid_o;
    commit_t commit_o;

    word_t       shadow [32];
    commit_t     exp_q [$];
    commit_t     head;
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;

    exec_core dut (.*);

    always #20 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    //////////////////////////////////////////////////////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    function automatic word_t ref_result(input op_e op, input word_t a, input word_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return prod[31:0];
        endcase
    endfunction

    function automatic instr_t make_instr(input op_e op, input int rd, input int rs1,
                                          input int rs2, input logic use_imm, input word_t imm);
        instr_t ins;
        ins.op      = op;
        ins.rd      = reg_addr_t'(rd);
        ins.rs1     = reg_addr_t'(rs1);
        ins.rs2     = reg_addr_t'(rs2);
        ins.use_imm = use_imm;
        ins.imm     = imm;
        return ins;
    endfunction

    // Update the shadow registers and queue the expected commit
    task automatic model_accept(input instr_t ins);
        word_t a;
        word_t b;
        word_t res;
        a   = shadow[ins.rs1];
        b   = ins.use_imm ? ins.imm : shadow[ins.rs2];
        res = ref_result(ins.op, a, b);
        if (ins.rd != 0) shadow[ins.rd] = res;
        exp_q.push_back('{rd: ins.rd, value: res});
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_instr(input instr_t ins);
        int waited;
        waited        = 0;
        instr_valid_i = 1'b1;
        instr_i       = ins;
        while (!instr_ready_o && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            waited++;
        end
        if (!instr_ready_o) begin
            $display("Timeout at %0t: instr_ready_o stayed low", $time);
            $display("Checks: %0d  errors: %0d  pending commits: %0d",
                     checks, errors, exp_q.size());
            $display("TESTS FAILED");
            $finish;
        end else begin
            model_accept(ins);
            @(negedge clk_i);
            instr_valid_i = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Commit checker
    //////////////////////////////////////////////////////////////////////

    // Outputs only move on the rising edge, so the falling edge is safe
    always @(negedge clk_i) begin
        if (rst_ni && commit_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: unexpected commit rd=%0d value=%h",
                         $time, commit_o.rd, commit_o.value);
                errors++;
            end else begin
                head = exp_q.pop_front();
                checks++;
                if (commit_o.rd !== head.rd || commit_o.value !== head.value) begin
                    $display("Error at %0t: commit rd=%0d value=%h, expected rd=%0d value=%h",
                             $time, commit_o.rd, commit_o.value, head.rd, head.value);
                    errors++;
                end
            end
        end
    end

    initial begin
        int waited;
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        lfsr_q        = 32'd99087;
        errors        = 0;
        checks        = 0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;

        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;

        // Idle after reset
        repeat (4) @(negedge clk_i);
        if (instr_ready_o !== 1'b1) begin
            $display("Error at %0t: instr_ready_o low after reset", $time);
            errors++;
        end

        // Every ALU operation on fixed operands, register and immediate forms
        send_instr(make_instr(OP_ADD, 1, 0, 0, 1'b1, 32'h8000_00F3));
        send_instr(make_instr(OP_ADD, 2, 0, 0, 1'b1, 32'h0000_0025));
        for (int i = 0; i < 8; i++) begin
            send_instr(make_instr(op_e'(i), 10 + i, 1, 2, 1'b0, '0));
            send_instr(make_instr(op_e'(i), 20 + i, 1, 0, 1'b1, 32'h0000_0F0F));
        end
        send_instr(make_instr(OP_SLT, 18, 2, 1, 1'b0, '0));

        // Dependent chain through the bypass
        send_instr(make_instr(OP_ADD, 3, 0, 0, 1'b1, 32'd5));
        send_instr(make_instr(OP_ADD, 3, 3, 3, 1'b0, '0));
        send_instr(make_instr(OP_SUB, 4, 3, 1, 1'b0, '0));
        send_instr(make_instr(OP_XOR, 5, 4, 3, 1'b0, '0));
        send_instr(make_instr(OP_SLL, 5, 5, 0, 1'b1, 32'd3));

        // Multiplies with a dependent add and a second multiply
        send_instr(make_instr(OP_MUL, 6, 1, 2, 1'b0, '0));
        send_instr(make_instr(OP_ADD, 7, 6, 6, 1'b0, '0));
        send_instr(make_instr(OP_MUL, 8, 6, 7, 1'b0, '0));
        send_instr(make_instr(OP_MUL, 9, 8, 0, 1'b1, 32'hDEAD_BEEF));
        send_instr(make_instr(OP_OR, 9, 9, 6, 1'b0, '0));

        // Register 0 is never written
        send_instr(make_instr(OP_ADD, 0, 1, 0, 1'b1, 32'd7));
        send_instr(make_instr(OP_ADD, 10, 0, 0, 1'b1, 32'd0));
        send_instr(make_instr(OP_OR, 11, 0, 1, 1'b0, '0));

        // Random stream
        for (int n = 0; n < 300; n++) begin
            instr_t ins;
            ins.op      = op_e'(rand_bits(4) % 9);
            ins.rd      = reg_addr_t'(rand_bits(5));
            ins.rs1     = reg_addr_t'(rand_bits(5));
            ins.rs2     = reg_addr_t'(rand_bits(5));
            ins.use_imm = 1'(rand_bits(1));
            ins.imm     = rand_bits(32);
            send_instr(ins);
        end

        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout at %0t: %0d commits never arrived", $time, exp_q.size());
            errors++;
        end

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
core_pkg.sv
reg_file.sv
alu.sv
mul_unit.sv
issue_stage.sv
exec_pipe.sv
exec_core.sv
exec_core_properties.sv
tb_exec_core.sv
